//--- Bender.yml
package:
  name: pipeCore

sources:
  - rtl/pipePkg.sv
  - rtl/regFile.sv
  - rtl/decodeStage.sv
  - rtl/forwardUnit.sv
  - rtl/execStage.sv
  - rtl/memStage.sv
  - rtl/pipeCore.sv
  - target: test
    files:
      - dv/pipeCoreTb.sv

//--- dv/pipeCoreTb.sv
// needs the default 64-word memory, cleared by the 16 reset cycles; stimulus is seeded random
`default_nettype none
`timescale 1ns/10ps

module pipeCoreTb;
	import pipePkg::*;

	localparam int clkPeriod   = 4;
	localparam int resetCycles = 16;
	localparam int nChain      = 200;
	localparam int nLoadUse    = 24;
	localparam int nStoreFwd   = 12;
	localparam int nZero       = 10;
	localparam int nLatency    = 60;
	localparam int totalInstr  = 4 + nChain + 5 * nLoadUse + 9 * nStoreFwd + 8 * nZero
		+ nLatency;

	typedef struct packed
	{
		regIdx_t     dest;
		word_t       data;
		logic [31:0] dueEdge;
	} expRetire_t;

	logic        clk = 1'b0;
	logic        rstN;
	logic        instrValid;
	instrWord_t  instr;
	logic        stall;
	logic        wbValid;
	regIdx_t     wbDest;
	word_t       wbData;

	integer      seed = 35;
	word_t       modelRegs [32];
	word_t       modelMem [64];
	expRetire_t  expQ [$];
	int unsigned edgeCount = 0;
	int          errorCount = 0;
	int          checkCount = 0;
	int          testCount = 0;
	int          stallSeen = 0;
	int          stallExpected = 0;
	// last instruction to enter execute, for load-use prediction
	logic        prevIsLoad = 1'b0;
	regIdx_t     prevDest = '0;
	int unsigned prevExEntry = 0;

	pipeCore #(
		.memAddrWidth (6)
	) u_pipeCore
	(
		.clk        (clk),
		.rstN       (rstN),
		.instrValid (instrValid),
		.instr      (instr),
		.stall      (stall),
		.wbValid    (wbValid),
		.wbDest     (wbDest),
		.wbData     (wbData)
	);

	always #(clkPeriod / 2) clk = ~clk;

	always @(posedge clk)
	begin
		edgeCount <= edgeCount + 1;
	end

	function automatic instrWord_t makeInstr(opcode_t op, regIdx_t d, regIdx_t s1,
		regIdx_t s2, logic [12:0] imm);
		return {op, d, s1, s2, imm};
	endfunction

	function automatic regIdx_t pickReg();
		regIdx_t r;
		r = 5'($random(seed));
		return (r == 5'd0) ? 5'd1 : r;
	endfunction

	function automatic regIdx_t nextReg(regIdx_t r);
		return (r == 5'd31) ? 5'd1 : r + 5'd1;
	endfunction

	function automatic logic [12:0] randImm();
		return 13'($random(seed));
	endfunction

	// mostly the two newest destinations
	function automatic regIdx_t pickSrc(regIdx_t last1, regIdx_t last2);
		case ($unsigned($random(seed)) % 4)
			0: return last1;
			1: return last2;
			2: return last1;
			default: return pickReg();
		endcase
	endfunction

	// golden model, in program order at acceptance
	task automatic predictInstr(input instrWord_t w, input int unsigned acceptEdge);
		opcode_t    op;
		regIdx_t    d;
		regIdx_t    s1;
		regIdx_t    s2;
		word_t      a;
		word_t      b;
		word_t      imm;
		word_t      res;
		logic       wbEn;
		logic       usesSrc2;
		logic       useStall;
		logic [5:0] addr;
		expRetire_t entry;
		op       = opcode_t'(w[31:28]);
		d        = w[27:23];
		s1       = w[22:18];
		s2       = w[17:13];
		imm      = {{19{w[12]}}, w[12:0]};
		a        = modelRegs[s1];
		b        = modelRegs[s2];
		res      = '0;
		wbEn     = 1'b1;
		addr     = 6'(a + imm);
		usesSrc2 = (op == opAdd) || (op == opSub) || (op == opAnd) || (op == opOr)
			|| (op == opStore);
		case (op)
			opAdd:    res = a + b;
			opSub:    res = a - b;
			opAnd:    res = a & b;
			opOr:     res = a | b;
			opAddImm: res = a + imm;
			opLoad:   res = modelMem[addr];
			opStore:
			begin
				modelMem[addr] = b;
				wbEn = 1'b0;
			end
			default:  wbEn = 1'b0;
		endcase
		// a load still in memory stage while its user sits in execute
		useStall = prevIsLoad && (prevDest != 5'd0) && (prevExEntry == acceptEdge)
			&& ((prevDest == s1) || (usesSrc2 && (prevDest == s2)));
		if (useStall)
			stallExpected++;
		prevIsLoad  = (op == opLoad);
		prevDest    = d;
		prevExEntry = acceptEdge + 1 + useStall;
		if (wbEn)
		begin
			entry.dest    = d;
			entry.data    = res;
			entry.dueEdge = acceptEdge + 3 + useStall;
			expQ.push_back(entry);
		end
		if (wbEn && (d != 5'd0))
			modelRegs[d] = res;
	endtask

	// called on a rising edge, returns on the acceptance edge
	task automatic sendInstr(input instrWord_t w);
		instrValid <= 1'b1;
		instr      <= w;
		@(posedge clk);
		while (stall)
			@(posedge clk);
		predictInstr(w, edgeCount);
	endtask

	task automatic drainPipe();
		instrValid <= 1'b0;
		instr      <= makeInstr(opNop, 5'd0, 5'd0, 5'd0, 13'd0);
		while (expQ.size() != 0)
			@(posedge clk);
		repeat (4)
			@(posedge clk);
	endtask

	task automatic runAluChain(input int n, input logic nearSources);
		regIdx_t last1;
		regIdx_t last2;
		regIdx_t d;
		regIdx_t s1;
		regIdx_t s2;
		last1 = pickReg();
		last2 = pickReg();
		for (int i = 0; i < n; i++)
		begin
			d  = pickReg();
			s1 = nearSources ? pickSrc(last1, last2) : pickReg();
			s2 = nearSources ? pickSrc(last1, last2) : pickReg();
			sendInstr(makeInstr(opcode_t'(4'($unsigned($random(seed)) % 5)), d, s1, s2,
				randImm()));
			last2 = last1;
			last1 = d;
		end
	endtask

	task automatic finishTest(input string name, input int errorsBefore);
		testCount++;
		checkCount++;
		assert (stallSeen == stallExpected)
		else
		begin
			$display("** Error @%0t: stall cycles expected %0d actual %0d", $time,
				stallExpected, stallSeen);
			errorCount++;
		end
		$display("test %0d %s done, %0d errors", testCount, name, errorCount - errorsBefore);
	endtask

	// retire checks against the queue head
	always @(posedge clk)
	begin
		expRetire_t head;
		if (rstN && stall)
			stallSeen++;
		if (rstN && wbValid)
		begin
			checkCount++;
			if (expQ.size() == 0)
			begin
				$display("error: wbValid pulsed at %0t with no result outstanding", $time);
				errorCount++;
			end
			else
			begin
				head = expQ.pop_front();
				assert (wbDest == head.dest)
				else
				begin
					$display("** Error @%0t: wbDest expected %0d actual %0d", $time,
						head.dest, wbDest);
					errorCount++;
				end
				assert (wbData == head.data)
				else
				begin
					$display("** Error @%0t: wbData expected %h actual %h", $time,
						head.data, wbData);
					errorCount++;
				end
				assert (edgeCount == head.dueEdge)
				else
				begin
					$display("** Error @%0t: wbValid edge expected %0d actual %0d", $time,
						head.dueEdge, edgeCount);
					errorCount++;
				end
			end
		end
	end

	initial
	begin
		int          errorsBefore;
		regIdx_t     rA;
		regIdx_t     rB;
		regIdx_t     rC;
		regIdx_t     rD;
		logic [12:0] off;
		for (int i = 0; i < 32; i++)
			modelRegs[i] = '0;
		for (int i = 0; i < 64; i++)
			modelMem[i] = '0;
		rstN       = 1'b0;
		instrValid = 1'b0;
		instr      = '0;
		repeat (resetCycles)
			@(posedge clk);
		rstN <= 1'b1;

		// idle after reset, then reads of untouched registers and memory
		errorsBefore = errorCount;
		repeat (4)
		begin
			@(posedge clk);
			checkCount++;
			assert (!stall && !wbValid)
			else
			begin
				$display("error: stall or wbValid high at %0t with no instruction", $time);
				errorCount++;
			end
		end
		rA = pickReg();
		rD = pickReg();
		sendInstr(makeInstr(opAddImm, rA, rA, 5'd0, randImm()));
		sendInstr(makeInstr(opAdd, nextReg(rA), rA, 5'd0, 13'd0));
		sendInstr(makeInstr(opLoad, nextReg(nextReg(rA)), 5'd0, 5'd0,
			13'($unsigned($random(seed)) % 64)));
		sendInstr(makeInstr(opOr, rD, rD, rD, 13'd0));
		drainPipe();
		finishTest("reset state", errorsBefore);

		errorsBefore = errorCount;
		runAluChain(nChain, 1'b1);
		drainPipe();
		finishTest("alu chains", errorsBefore);

		// dependent followers on src1, src2 and store data, then an independent one
		errorsBefore = errorCount;
		for (int k = 0; k < nLoadUse; k++)
		begin
			rA  = pickReg();
			rB  = nextReg(rA);
			rC  = nextReg(rB);
			rD  = pickReg();
			off = 13'($unsigned($random(seed)) % 64);
			sendInstr(makeInstr(opAddImm, rA, 5'd0, 5'd0, off));
			sendInstr(makeInstr(opAddImm, rB, 5'd0, 5'd0, randImm()));
			sendInstr(makeInstr(opStore, 5'd0, rA, rB, 13'd0));
			sendInstr(makeInstr(opLoad, rC, rA, 5'd0, 13'd0));
			case (k % 4)
				0: sendInstr(makeInstr(opAdd, rD, rC, rB, 13'd0));
				1: sendInstr(makeInstr(opSub, rD, rB, rC, 13'd0));
				2: sendInstr(makeInstr(opStore, 5'd0, rA, rC, 13'd1));
				default: sendInstr(makeInstr(opOr, rD, rA, rB, 13'd0));
			endcase
		end
		drainPipe();
		finishTest("load-use stall", errorsBefore);

		// store data from slot 1, then from slot 2, read back by loads
		errorsBefore = errorCount;
		for (int k = 0; k < nStoreFwd; k++)
		begin
			rA  = pickReg();
			rB  = nextReg(rA);
			rC  = nextReg(rB);
			rD  = nextReg(rC);
			off = 13'($unsigned($random(seed)) % 32);
			sendInstr(makeInstr(opAddImm, rA, 5'd0, 5'd0, off));
			sendInstr(makeInstr(opAddImm, rB, rB, 5'd0, randImm()));
			sendInstr(makeInstr(opStore, 5'd0, rA, rB, 13'd0));
			sendInstr(makeInstr(opAddImm, rC, 5'd0, 5'd0, randImm()));
			sendInstr(makeInstr(opOr, rD, rA, rA, 13'd0));
			sendInstr(makeInstr(opStore, 5'd0, rA, rC, 13'd32));
			sendInstr(makeInstr(opLoad, rD, rA, 5'd0, 13'd0));
			sendInstr(makeInstr(opLoad, rB, rA, 5'd0, 13'd32));
			sendInstr(makeInstr(opAdd, rC, rD, rB, 13'd0));
		end
		drainPipe();
		finishTest("store data forwarding", errorsBefore);

		// dest 0 retires its data but never forwards or stalls
		errorsBefore = errorCount;
		for (int k = 0; k < nZero; k++)
		begin
			rA = pickReg();
			rB = nextReg(rA);
			sendInstr(makeInstr(opAddImm, 5'd0, rA, 5'd0, randImm()));
			sendInstr(makeInstr(opAdd, rB, 5'd0, 5'd0, 13'd0));
			sendInstr(makeInstr(opAddImm, 5'd0, rB, 5'd0, randImm()));
			sendInstr(makeInstr(opAddImm, rA, rA, 5'd0, 13'd1));
			sendInstr(makeInstr(opOr, rB, 5'd0, rA, 13'd0));
			sendInstr(makeInstr(opLoad, 5'd0, rA, 5'd0, 13'd3));
			sendInstr(makeInstr(opAdd, rA, 5'd0, rB, 13'd0));
			sendInstr(makeInstr(opStore, 5'd0, 5'd0, 5'd0, 13'd7));
		end
		drainPipe();
		finishTest("register 0", errorsBefore);

		// no loads, so every retire lands 3 edges after acceptance
		errorsBefore = errorCount;
		runAluChain(nLatency, 1'b0);
		drainPipe();
		finishTest("latency", errorsBefore);

		$display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// 8 cycles per instruction covers stalls and drains
	initial
	begin
		#((totalInstr * 8 + resetCycles) * clkPeriod);
		$display("error: watchdog expired at %0t before the tests finished", $time);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/decodeStage.sv
// the source must hold instr while stall is high; unknown opcodes and nop enter as bubbles
`default_nettype none
`timescale 1ns/10ps

module decodeStage
(
	input  wire                      clk,
	input  wire                      rstN,
	input  wire                      instrValid,
	input  wire pipePkg::instrWord_t instr,
	input  wire                      stall,
	output pipePkg::regIdx_t         rdAddr1,
	output pipePkg::regIdx_t         rdAddr2,
	input  wire pipePkg::word_t      rdData1,
	input  wire pipePkg::word_t      rdData2,
	output pipePkg::idExReg_t        idEx
);
	import pipePkg::*;

	opcode_t  opcode;
	idExReg_t nextIdEx;
	logic     isLive;

	assign opcode = opcode_t'(instr[31:28]);

	// a held instruction rereads its sources, else the write retiring
	// during the stall would be lost to it
	assign rdAddr1 = stall ? idEx.src1 : instr[22:18];
	assign rdAddr2 = stall ? idEx.src2 : instr[17:13];

	always_comb
	begin
		nextIdEx         = '0;
		nextIdEx.opcode  = opcode;
		nextIdEx.dest    = instr[27:23];
		nextIdEx.src1    = instr[22:18];
		nextIdEx.src2    = instr[17:13];
		nextIdEx.rdData1 = rdData1;
		nextIdEx.rdData2 = rdData2;
		nextIdEx.imm     = {{19{instr[12]}}, instr[12:0]};
		case (opcode)
			opAdd, opSub, opAnd, opOr:
				nextIdEx.wbEn = 1'b1;
			opAddImm:
			begin
				nextIdEx.isImm = 1'b1;
				nextIdEx.wbEn  = 1'b1;
			end
			opLoad:
			begin
				nextIdEx.isImm   = 1'b1;
				nextIdEx.wbEn    = 1'b1;
				nextIdEx.memRead = 1'b1;
			end
			opStore:
			begin
				nextIdEx.isImm    = 1'b1;
				nextIdEx.memWrite = 1'b1;
			end
			default:
				nextIdEx.wbEn = 1'b0;
		endcase
		isLive = instrValid && (nextIdEx.wbEn || nextIdEx.memWrite);
		// bubble
		if (!isLive)
		begin
			nextIdEx.isImm    = 1'b0;
			nextIdEx.wbEn     = 1'b0;
			nextIdEx.memRead  = 1'b0;
			nextIdEx.memWrite = 1'b0;
		end
		nextIdEx.valid = isLive;
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			idEx.isImm    <= 1'b0;
			idEx.wbEn     <= 1'b0;
			idEx.memRead  <= 1'b0;
			idEx.memWrite <= 1'b0;
			idEx.valid    <= 1'b0;
		end
		else if (stall)
		begin
			idEx.rdData1 <= rdData1;
			idEx.rdData2 <= rdData2;
		end
		else
		begin
			idEx <= nextIdEx;
		end
	end

endmodule

`default_nettype wire

//--- rtl/execStage.sv
// stall is combinational from the stage registers; a stalled cycle sends a bubble to memory
`default_nettype none
`timescale 1ns/10ps

module execStage
(
	input  wire                     clk,
	input  wire                     rstN,
	input  wire pipePkg::idExReg_t  idEx,
	input  wire pipePkg::memWbReg_t memWb,
	output pipePkg::exMemReg_t      exMem,
	output logic                    stall
);
	import pipePkg::*;

	word_t opA;
	word_t fwdSrc2;
	word_t opB;
	word_t storeData;
	word_t aluOut;

	// slot 1 is fed back from this stage's own register
	forwardUnit u_forwardUnit
	(
		.idEx             (idEx),
		.exMem            (exMem),
		.memWb            (memWb),
		.srcOut1          (opA),
		.srcOut2          (fwdSrc2),
		.memOut           (storeData),
		.loadForwardStall (stall)
	);

	assign opB = idEx.isImm ? idEx.imm : fwdSrc2;

	always_comb
	begin
		case (idEx.opcode)
			opSub:   aluOut = opA - opB;
			opAnd:   aluOut = opA & opB;
			opOr:    aluOut = opA | opB;
			// add, addImm and load/store addresses
			default: aluOut = opA + opB;
		endcase
	end

	always_ff @(posedge clk)
	begin
		exMem.dest      <= idEx.dest;
		exMem.aluResult <= aluOut;
		exMem.storeData <= storeData;
		if (!rstN || stall)
		begin
			exMem.wbEn     <= 1'b0;
			exMem.memRead  <= 1'b0;
			exMem.memWrite <= 1'b0;
			exMem.valid    <= 1'b0;
		end
		else
		begin
			exMem.wbEn     <= idEx.wbEn;
			exMem.memRead  <= idEx.memRead;
			exMem.memWrite <= idEx.memWrite;
			exMem.valid    <= idEx.valid;
		end
	end

endmodule

`default_nettype wire

//--- rtl/forwardUnit.sv
// slot 1 is execute/memory, slot 2 is memory/writeback; a load in slot 1 stalls instead of forwarding
`default_nettype none
`timescale 1ns/10ps

module forwardUnit
(
	input  wire pipePkg::idExReg_t  idEx,
	input  wire pipePkg::exMemReg_t exMem,
	input  wire pipePkg::memWbReg_t memWb,
	output pipePkg::word_t          srcOut1,
	output pipePkg::word_t          srcOut2,
	output pipePkg::word_t          memOut,
	output logic                    loadForwardStall
);

	logic slot1Ok;
	logic slot2Ok;
	logic src1Slot1;
	logic src1Slot2;
	logic src2Slot1;
	logic src2Slot2;
	logic usesSrc2;

	// a slot can forward only a finished result to a real register
	assign slot1Ok = exMem.valid & exMem.wbEn & ~exMem.memRead & (|exMem.dest);
	assign slot2Ok = memWb.valid & memWb.wbEn & (|memWb.dest);

	assign src1Slot1 = slot1Ok & (idEx.src1 == exMem.dest);
	assign src1Slot2 = slot2Ok & (idEx.src1 == memWb.dest);
	assign src2Slot1 = slot1Ok & (idEx.src2 == exMem.dest);
	assign src2Slot2 = slot2Ok & (idEx.src2 == memWb.dest);

	// slot 1 is newer and wins
	always_comb
	begin
		if (src1Slot1)
			srcOut1 = exMem.aluResult;
		else if (src1Slot2)
			srcOut1 = memWb.result;
		else
			srcOut1 = idEx.rdData1;

		if (src2Slot1 && !idEx.isImm)
			srcOut2 = exMem.aluResult;
		else if (src2Slot2 && !idEx.isImm)
			srcOut2 = memWb.result;
		else
			srcOut2 = idEx.rdData2;

		// store data, whatever isImm says
		if (src2Slot1)
			memOut = exMem.aluResult;
		else if (src2Slot2)
			memOut = memWb.result;
		else
			memOut = idEx.rdData2;
	end

	// stores read src2 as data even though they are immediate ops
	assign usesSrc2 = ~idEx.isImm | idEx.memWrite;

	assign loadForwardStall = idEx.valid & exMem.valid & exMem.memRead & (|exMem.dest)
		& ((idEx.src1 == exMem.dest) | (usesSrc2 & (idEx.src2 == exMem.dest)));

endmodule

`default_nettype wire

//--- rtl/memStage.sv
// memory clears 4 words per reset cycle, so rstN must stay low 2**(memAddrWidth-2) cycles
`default_nettype none
`timescale 1ns/10ps

module memStage
#(
	parameter int memAddrWidth = 6
)
(
	input  wire                     clk,
	input  wire                     rstN,
	input  wire pipePkg::exMemReg_t exMem,
	output pipePkg::memWbReg_t      memWb,
	output logic                    wbValid,
	output pipePkg::regIdx_t        wbDest,
	output pipePkg::word_t          wbData
);
	import pipePkg::*;

	typedef logic [memAddrWidth-1:0] memAddr_t;

	word_t                   mem [2**memAddrWidth];
	memAddr_t                memAddr;
	// clear sweep position, advances only in reset
	logic [memAddrWidth-3:0] clrPtr = '0;

	// word address from the low bits of the ALU result
	assign memAddr = exMem.aluResult[memAddrWidth-1:0];

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 4; i++)
			begin
				mem[{clrPtr, 2'(i)}] <= '0;
			end
			clrPtr <= clrPtr + 1'b1;
		end
		else if (exMem.valid && exMem.memWrite)
		begin
			mem[memAddr] <= exMem.storeData;
		end
	end

	// the read shares its edge with the writeback register
	always_ff @(posedge clk)
	begin
		memWb.dest   <= exMem.dest;
		memWb.result <= exMem.memRead ? mem[memAddr] : exMem.aluResult;
		if (!rstN)
		begin
			memWb.wbEn  <= 1'b0;
			memWb.valid <= 1'b0;
		end
		else
		begin
			memWb.wbEn  <= exMem.wbEn;
			memWb.valid <= exMem.valid;
		end
	end

	// stores and bubbles retire without a pulse
	assign wbValid = memWb.valid & memWb.wbEn;
	assign wbDest  = memWb.dest;
	assign wbData  = memWb.result;

endmodule

`default_nettype wire

//--- rtl/pipeCore.sv
// hold instr while stall is high; results retire 3 cycles after acceptance plus 1 per stall
`default_nettype none
`timescale 1ns/10ps

module pipeCore
#(
	parameter int memAddrWidth = 6
)
(
	input  wire                      clk,
	input  wire                      rstN,
	input  wire                      instrValid,
	input  wire pipePkg::instrWord_t instr,
	output logic                     stall,
	output logic                     wbValid,
	output pipePkg::regIdx_t         wbDest,
	output pipePkg::word_t           wbData
);
	import pipePkg::*;

	regIdx_t   rdAddr1;
	regIdx_t   rdAddr2;
	word_t     rdData1;
	word_t     rdData2;
	idExReg_t  idEx;
	exMemReg_t exMem;
	memWbReg_t memWb;

	// write port driven by the writeback register
	regFile u_regFile
	(
		.clk     (clk),
		.rstN    (rstN),
		.rdAddr1 (rdAddr1),
		.rdAddr2 (rdAddr2),
		.rdData1 (rdData1),
		.rdData2 (rdData2),
		.wrEn    (wbValid),
		.wrAddr  (memWb.dest),
		.wrData  (memWb.result)
	);

	decodeStage u_decodeStage
	(
		.clk        (clk),
		.rstN       (rstN),
		.instrValid (instrValid),
		.instr      (instr),
		.stall      (stall),
		.rdAddr1    (rdAddr1),
		.rdAddr2    (rdAddr2),
		.rdData1    (rdData1),
		.rdData2    (rdData2),
		.idEx       (idEx)
	);

	execStage u_execStage
	(
		.clk   (clk),
		.rstN  (rstN),
		.idEx  (idEx),
		.memWb (memWb),
		.exMem (exMem),
		.stall (stall)
	);

	memStage #(
		.memAddrWidth (memAddrWidth)
	) u_memStage
	(
		.clk     (clk),
		.rstN    (rstN),
		.exMem   (exMem),
		.memWb   (memWb),
		.wbValid (wbValid),
		.wbDest  (wbDest),
		.wbData  (wbData)
	);

endmodule

`default_nettype wire

//--- rtl/pipePkg.sv
// opcodes outside the listed kinds decode as bubbles; the immediate is 13 bits, signed
`default_nettype none

package pipePkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  regIdx_t;

	// opcode 31:28, dest 27:23, src1 22:18, src2 17:13, imm 12:0
	typedef logic [31:0] instrWord_t;

	typedef enum logic [3:0]
	{
		opAdd    = 4'h0,
		opSub    = 4'h1,
		opAnd    = 4'h2,
		opOr     = 4'h3,
		opAddImm = 4'h4,
		opLoad   = 4'h5,
		opStore  = 4'h6,
		opNop    = 4'hf
	} opcode_t;

	typedef struct packed
	{
		opcode_t opcode;
		regIdx_t dest;
		regIdx_t src1;
		regIdx_t src2;
		word_t   rdData1;
		word_t   rdData2;
		// already sign extended
		word_t   imm;
		logic    isImm;
		logic    wbEn;
		logic    memRead;
		logic    memWrite;
		logic    valid;
	} idExReg_t;

	typedef struct packed
	{
		regIdx_t dest;
		// doubles as the data memory address
		word_t   aluResult;
		word_t   storeData;
		logic    wbEn;
		logic    memRead;
		logic    memWrite;
		logic    valid;
	} exMemReg_t;

	typedef struct packed
	{
		regIdx_t dest;
		word_t   result;
		logic    wbEn;
		logic    valid;
	} memWbReg_t;

endpackage

`default_nettype wire

//--- rtl/regFile.sv
// register 0 is hardwired to zero; a read of the register written this cycle sees the new value
`default_nettype none
`timescale 1ns/10ps

module regFile
(
	input  wire                   clk,
	input  wire                   rstN,
	input  wire pipePkg::regIdx_t rdAddr1,
	input  wire pipePkg::regIdx_t rdAddr2,
	output pipePkg::word_t        rdData1,
	output pipePkg::word_t        rdData2,
	input  wire                   wrEn,
	input  wire pipePkg::regIdx_t wrAddr,
	input  wire pipePkg::word_t   wrData
);
	import pipePkg::*;

	// no storage behind register 0
	word_t regs [1:31];

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 1; i < 32; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wrEn && (wrAddr != '0))
		begin
			regs[wrAddr] <= wrData;
		end
	end

	// bypass the writeback value to a same-cycle read
	assign rdData1 = (rdAddr1 == '0) ? '0 :
		(wrEn && (wrAddr == rdAddr1)) ? wrData : regs[rdAddr1];
	assign rdData2 = (rdAddr2 == '0) ? '0 :
		(wrEn && (wrAddr == rdAddr2)) ? wrData : regs[rdAddr2];

endmodule

`default_nettype wire

//--- verilog.f
rtl/pipePkg.sv
rtl/regFile.sv
rtl/decodeStage.sv
rtl/forwardUnit.sv
rtl/execStage.sv
rtl/memStage.sv
rtl/pipeCore.sv
dv/pipeCoreTb.sv
